//--- Bender.yml
package:
  name: packetizer

dependencies: {}

sources:
  # packages first, then the RTL in compile order
  - hdl/fifoPkg.sv
  - hdl/packetPkg.sv
  - hdl/syncFifo.sv
  - hdl/fastFifo.sv
  - hdl/flushTimer.sv
  - hdl/burstCtrl.sv
  - hdl/packetizer.sv

  - target: simulation
    files:
      - sim/packetChecker.sv
      - sim/packetizerTb.sv

//--- hdl/burstCtrl.sv
`timescale 1ns/1ps

module burstCtrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold,
    input  fifoPkg::usedw_t     usedw,
    input  logic                empty,
    input  logic                expired,
    output logic                timerEnable,
    input  logic                outLast,
    output logic                readEnable,
    output packetPkg::beatTag_t readTag
);

    packetPkg::ctrlState_t state;
    packetPkg::beatCount_t remaining;
    logic firstPending;     // next read opens the packet
    logic enoughWords;
    logic startPacket;
    logic finalRead;

    assign enoughWords = (usedw >= fifoPkg::usedw_t'(packetPkg::BurstLen));

    // timer only runs while words wait and a packet could start
    assign timerEnable = (state == packetPkg::Idle) && !hold && !empty;
    assign startPacket = timerEnable && (enoughWords || expired);

    assign readEnable = (state == packetPkg::Burst);
    assign finalRead = (remaining == packetPkg::beatCount_t'(1));

    always_comb begin
        readTag.first = readEnable && firstPending;
        readTag.last = readEnable && finalRead;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= packetPkg::Idle;
            remaining <= '0;
            firstPending <= 1'b0;
        end else begin
            case (state)
                packetPkg::Idle: begin
                    if (startPacket) begin
                        state <= packetPkg::Burst;
                        firstPending <= 1'b1;
                        // smaller of usedw and BurstLen
                        if (enoughWords) begin
                            remaining <= packetPkg::beatCount_t'(packetPkg::BurstLen);
                        end else begin
                            remaining <= packetPkg::beatCount_t'(usedw);
                        end
                    end
                end
                packetPkg::Burst: begin
                    firstPending <= 1'b0;
                    remaining <= remaining - 1'b1;
                    if (finalRead) begin
                        state <= packetPkg::Drain;
                    end
                end
                packetPkg::Drain: begin
                    if (outLast) begin        // last beat left the pipe
                        state <= packetPkg::Idle;
                    end
                end
                default: state <= packetPkg::Idle;
            endcase
        end
    end

    // packet length was latched from occupancy, so reads never underflow
    assert property (@(posedge clk) disable iff (rst)
        readEnable |-> !empty)
        else $error("burstCtrl: read issued on an empty FIFO");

endmodule

//--- hdl/fastFifo.sv
`timescale 1ns/1ps

module fastFifo (
    input  logic                clk,
    input  logic                rst,
    input  logic                writeEnable,
    input  fifoPkg::word_t      dataIn,
    output logic                full,
    output fifoPkg::usedw_t     usedw,
    input  logic                readEnable,
    input  packetPkg::beatTag_t readTag,
    output logic                empty,
    output packetPkg::beat_t    outBeat
);

    logic writeAccepted;
    logic readAccepted;
    fifoPkg::word_t headWord;

    packetPkg::beat_t pipeIn;
    packetPkg::beat_t pipe [fifoPkg::ReadLatency];

    // protect the ring against overflow and underflow
    assign writeAccepted = writeEnable && !full;
    assign readAccepted = readEnable && !empty;

    syncFifo fifo_i (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeAccepted),
        .dataIn      (dataIn),
        .readEnable  (readAccepted),
        .dataOut     (headWord),
        .empty       (empty),
        .full        (full),
        .usedw       (usedw)
    );

    // head word is taken in the same cycle the read is accepted
    always_comb begin
        pipeIn.valid = readAccepted;
        pipeIn.first = readTag.first;
        pipeIn.last = readTag.last;
        pipeIn.data = headWord;
    end

    // delay pipe, only valid bits are cleared on reset
    always_ff @(posedge clk) begin
        pipe[0] <= pipeIn;
        for (int i = 1; i < fifoPkg::ReadLatency; i++) begin
            pipe[i] <= pipe[i-1];
        end
        if (rst) begin
            for (int i = 0; i < fifoPkg::ReadLatency; i++) begin
                pipe[i].valid <= 1'b0;
            end
        end
    end

    assign outBeat = pipe[fifoPkg::ReadLatency-1];

    // a full ring can lose at most one word per cycle
    assert property (@(posedge clk) disable iff (rst)
        (usedw == '1) |=> (usedw != '0))
        else $error("fastFifo: occupancy went from full to empty in one cycle");

    // nothing may leave the pipe right after reset
    assert property (@(posedge clk)
        rst |=> !outBeat.valid)
        else $error("fastFifo: valid beat on the cycle after reset");

endmodule

//--- hdl/fifoPkg.sv
package fifoPkg;

    // word and ring geometry
    localparam int DataWidth = 16;
    localparam int DepthLog2 = 5;   // 32 slots, one kept free to tell full from empty

    // accepted read to output beat
    localparam int ReadLatency = 3;

    // one data word
    typedef logic [DataWidth-1:0] word_t;

    // occupancy, also the width of the ring heads
    typedef logic [DepthLog2-1:0] usedw_t;

endpackage

//--- hdl/flushTimer.sv
`timescale 1ns/1ps

module flushTimer (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    output logic expired
);

    packetPkg::timer_t count;
    logic atLimit;

    // last cycle of a run of FlushTimeout enabled cycles
    assign atLimit = (count == packetPkg::timer_t'(packetPkg::FlushTimeout - 1));
    assign expired = enable && atLimit;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!enable) begin
            count <= '0;                // any gap restarts the run
        end else if (atLimit) begin
            count <= '0;                // pulse, then start a new run
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

//--- hdl/packetPkg.sv
package packetPkg;

    localparam int BurstLen = 8;        // longest packet in words
    localparam int FlushTimeout = 16;   // idle cycles before a partial packet goes out

    typedef logic [4:0] timer_t;        // flush timer count
    typedef logic [3:0] beatCount_t;    // words left in the current packet

    // controller states
    typedef enum logic [1:0] {
        Idle,
        Burst,
        Drain
    } ctrlState_t;

    // framing flags that ride along with a read
    typedef struct packed {
        logic first;
        logic last;
    } beatTag_t;

    // one outgoing beat
    typedef struct packed {
        logic           valid;
        logic           first;
        logic           last;
        fifoPkg::word_t data;
    } beat_t;

endpackage

//--- hdl/packetizer.sv
`timescale 1ns/1ps

module packetizer (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeEnable,
    input  fifoPkg::word_t   dataIn,
    output logic             full,
    input  logic             hold,
    output packetPkg::beat_t outBeat
);

    fifoPkg::usedw_t usedw;
    logic empty;
    logic readEnable;
    packetPkg::beatTag_t readTag;
    logic timerEnable;
    logic expired;
    logic outLast;

    assign outLast = outBeat.valid && outBeat.last;   // closes the packet in flight

    fastFifo fifo_i (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .full        (full),
        .usedw       (usedw),
        .readEnable  (readEnable),
        .readTag     (readTag),
        .empty       (empty),
        .outBeat     (outBeat)
    );

    flushTimer timer_i (
        .clk     (clk),
        .rst     (rst),
        .enable  (timerEnable),
        .expired (expired)
    );

    burstCtrl ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .usedw       (usedw),
        .empty       (empty),
        .expired     (expired),
        .timerEnable (timerEnable),
        .outLast     (outLast),
        .readEnable  (readEnable),
        .readTag     (readTag)
    );

endmodule

//--- hdl/syncFifo.sv
`timescale 1ns/1ps

module syncFifo (
    input  logic            clk,
    input  logic            rst,
    input  logic            writeEnable,
    input  fifoPkg::word_t  dataIn,
    input  logic            readEnable,
    output fifoPkg::word_t  dataOut,
    output logic            empty,
    output logic            full,
    output fifoPkg::usedw_t usedw
);

    // ring storage, one slot always left free
    fifoPkg::word_t mem [1 << fifoPkg::DepthLog2];

    fifoPkg::usedw_t writeHead;
    fifoPkg::usedw_t readHead;

    assign usedw = writeHead - readHead;    // wraps by unsigned overflow
    assign empty = (usedw == '0);
    assign full = (usedw == '1);            // 31 words held
    assign dataOut = mem[readHead];         // showahead, head word always visible

    // heads
    always_ff @(posedge clk) begin
        if (rst) begin
            writeHead <= '0;
            readHead <= '0;
        end else begin
            if (writeEnable) begin
                writeHead <= writeHead + 1'b1;
            end
            if (readEnable) begin
                readHead <= readHead + 1'b1;
            end
        end
    end

    // storage write
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeHead] <= dataIn;
        end
    end

endmodule

//--- sim/packetChecker.sv
`timescale 1ns/1ps

module packetChecker (
    input  logic             clk,
    input  logic             rst,
    input  logic             writeEnable,
    input  fifoPkg::word_t   dataIn,
    input  logic             full,
    input  logic             hold,
    input  packetPkg::beat_t outBeat,
    output int               mismatchCount,
    output int               failCount
);

    fifoPkg::word_t refQueue [$];   // accepted words not yet seen at the output
    int expLens [$];
    bit lensChecked;
    bit anyWrite;
    bit inPacket;
    bit fullSeen;
    int expAccepted;
    int rowAccepted;
    int maxLatency;
    int cycle;
    int lastWriteCycle;
    int pktLen;

    initial begin
        mismatchCount = 0;
        failCount = 0;
        anyWrite = 1'b0;
        inPacket = 1'b0;
        fullSeen = 1'b0;
        lensChecked = 1'b0;
        expAccepted = 0;
        rowAccepted = 0;
        maxLatency = 0;
        cycle = 0;
        lastWriteCycle = 0;
        pktLen = 0;
    end

    task automatic reportFailure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        failCount++;
    endtask

    task automatic beginRow(input int accepted, input bit checkLens, input int latency);
        expAccepted = accepted;
        rowAccepted = 0;
        lensChecked = checkLens;
        maxLatency = latency;
        expLens.delete();
    endtask

    task automatic expectPacket(input int len);
        expLens.push_back(len);
    endtask

    task automatic endRow();
        if (rowAccepted != expAccepted) begin
            reportFailure($sformatf("FIFO took %0d words, expected %0d",
                                    rowAccepted, expAccepted));
        end
        if (expLens.size() != 0) begin
            reportFailure($sformatf("%0d expected packets never arrived", expLens.size()));
        end
    endtask

    task automatic finalCheck();
        if (refQueue.size() != 0) begin
            reportFailure($sformatf("%0d written words never came out", refQueue.size()));
        end
        if (inPacket) begin
            reportFailure("last packet was never closed");
        end
    endtask

    // one valid output beat
    task automatic checkBeat();
        fifoPkg::word_t expWord;
        int expLen;
        if (refQueue.size() == 0) begin
            reportFailure("valid beat with no word waiting");
        end else begin
            expWord = refQueue.pop_front();
            if (outBeat.data !== expWord) begin
                $display("MISMATCH outBeat.data: got %h, expected %h", outBeat.data, expWord);
                mismatchCount++;
            end
        end
        if (!inPacket && !outBeat.first) reportFailure("packet opened without first flag");
        if (inPacket && outBeat.first) reportFailure("first flag inside an open packet");
        if (outBeat.first) pktLen = 0;
        pktLen++;
        inPacket = 1'b1;
        if (outBeat.last) begin
            inPacket = 1'b0;
            if (pktLen > packetPkg::BurstLen) begin
                reportFailure($sformatf("packet of %0d beats is too long", pktLen));
            end
            if (lensChecked) begin
                if (expLens.size() == 0) begin
                    reportFailure($sformatf("unexpected packet of %0d beats", pktLen));
                end else begin
                    expLen = expLens.pop_front();
                    if (pktLen != expLen) begin
                        reportFailure($sformatf("packet of %0d beats, expected %0d",
                                                pktLen, expLen));
                    end
                end
            end
            if (maxLatency > 0 && cycle - lastWriteCycle > maxLatency) begin
                reportFailure($sformatf("last beat came %0d cycles after the last write",
                                        cycle - lastWriteCycle));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            cycle++;
            if (!anyWrite && (outBeat.valid || full)) begin
                reportFailure("valid beat or full seen before the first write");
            end
            if (outBeat.valid) checkBeat();
            if (writeEnable && !full) begin     // accepted write
                refQueue.push_back(dataIn);
                anyWrite = 1'b1;
                rowAccepted++;
                lastWriteCycle = cycle;
            end
            if (hold && fullSeen && !full) reportFailure("full dropped while hold was high");
            fullSeen = hold && (fullSeen || full);
        end
    end

endmodule

//--- sim/packetizerTb.sv
`timescale 1ns/1ps

module packetizerTb;

    localparam int NumRows = 5;

    // one stimulus row, numPkts of -1 leaves packet lengths unchecked
    typedef struct packed {
        int             words;
        int             gap;        // cycles after each write
        logic           hold;
        int             idle;       // cycles after the row
        int             accepted;   // words the FIFO should take
        int             numPkts;
        int             latency;    // 0 means no latency bound
        logic [3:0][7:0] lens;      // expected packet lengths, entry 0 first
    } row_t;

    logic clk;
    logic rst;
    logic writeEnable;
    fifoPkg::word_t dataIn;
    logic hold;
    logic full;
    packetPkg::beat_t outBeat;
    int mismatchCount;
    int failCount;

    row_t rows [NumRows];
    int rowCount;
    int seedResult;
    int cycleCount = 0;
    int cycleLimit = 1_000_000;     // replaced at time 0 from the table

    packetizer packetizer_i (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (writeEnable),
        .dataIn      (dataIn),
        .full        (full),
        .hold        (hold),
        .outBeat     (outBeat)
    );

    packetChecker chk_i (
        .clk           (clk),
        .rst           (rst),
        .writeEnable   (writeEnable),
        .dataIn        (dataIn),
        .full          (full),
        .hold          (hold),
        .outBeat       (outBeat),
        .mismatchCount (mismatchCount),
        .failCount     (failCount)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout, run went past %0d cycles", cycleLimit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic addRow(input int words, input int gap, input logic holdLevel,
                          input int idle, input int accepted, input int numPkts,
                          input int latency, input logic [3:0][7:0] lens);
        rows[rowCount] = {words, gap, holdLevel, idle, accepted, numPkts, latency, lens};
        rowCount++;
    endtask

    // called on a falling edge, leaves on a falling edge
    task automatic applyRow(input row_t r);
        chk_i.beginRow(r.accepted, r.numPkts >= 0, r.latency);
        for (int p = 0; p < r.numPkts; p++) begin
            chk_i.expectPacket(int'(r.lens[p]));
        end
        hold = r.hold;
        for (int i = 0; i < r.words; i++) begin
            writeEnable = 1'b1;
            dataIn = fifoPkg::word_t'($urandom);
            @(negedge clk);
            writeEnable = 1'b0;
            repeat (r.gap) @(negedge clk);
        end
        repeat (r.idle) @(negedge clk);
        chk_i.endRow();
    endtask

    initial begin
        seedResult = $urandom(32'hee74_70dc);
        rst = 1'b1;
        writeEnable = 1'b0;
        dataIn = '0;
        hold = 1'b0;
        rowCount = 0;

        addRow(8, 0, 1'b0, 30, 8, 1, 0, 32'h0000_0008);     // one full burst
        addRow(3, 0, 1'b0, 40, 3, 1,
               packetPkg::FlushTimeout + packetPkg::BurstLen + 8, 32'h0000_0003);
        addRow(40, 0, 1'b1, 10, 31, 0, 0, '0);              // overflow under hold
        addRow(0, 0, 1'b0, 100, 0, 4, 0, 32'h0708_0808);    // drain after hold falls
        addRow(20, 2, 1'b0, 60, 20, -1, 0, '0);             // spaced writes

        cycleLimit = 0;
        for (int r = 0; r < rowCount; r++) begin
            cycleLimit += rows[r].words * (1 + rows[r].gap) + rows[r].idle + 64;
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < rowCount; r++) begin
            applyRow(rows[r]);
        end

        chk_i.finalCheck();
        $display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
hdl/fifoPkg.sv
hdl/packetPkg.sv
hdl/syncFifo.sv
hdl/fastFifo.sv
hdl/flushTimer.sv
hdl/burstCtrl.sv
hdl/packetizer.sv
sim/packetChecker.sv
sim/packetizerTb.sv
